// File: hdl/mips_isa_pkg.sv
package mips_isa_pkg;

   // basic machine widths
   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_idx_t;
   // memories are word addressed, byte offset dropped
   typedef logic [29:0] waddr_t;

   // instruction field widths
   typedef logic [5:0]  opcode_t;
   typedef logic [5:0]  funct_t;
   typedef logic [4:0]  shamt_t;
   typedef logic [15:0] imm16_t;

   // r-type view of an instruction word
   // i-type immediate overlays rd, shamt and funct
   typedef struct packed {
      opcode_t  opcode;
      reg_idx_t rs;
      reg_idx_t rt;
      reg_idx_t rd;
      shamt_t   shamt;
      funct_t   funct;
   } instr_t;

   // primary opcodes
   localparam opcode_t op_rtype = 6'h00;
   localparam opcode_t op_addi  = 6'h08;
   localparam opcode_t op_addiu = 6'h09;
   localparam opcode_t op_slti  = 6'h0a;
   localparam opcode_t op_andi  = 6'h0c;
   localparam opcode_t op_ori   = 6'h0d;
   localparam opcode_t op_xori  = 6'h0e;
   localparam opcode_t op_lui   = 6'h0f;
   localparam opcode_t op_lw    = 6'h23;
   localparam opcode_t op_sw    = 6'h2b;

   // r-type function codes
   localparam funct_t fn_sll  = 6'h00;
   localparam funct_t fn_srl  = 6'h02;
   localparam funct_t fn_sra  = 6'h03;
   localparam funct_t fn_add  = 6'h20;
   localparam funct_t fn_addu = 6'h21;
   localparam funct_t fn_sub  = 6'h22;
   localparam funct_t fn_subu = 6'h23;
   localparam funct_t fn_and  = 6'h24;
   localparam funct_t fn_or   = 6'h25;
   localparam funct_t fn_xor  = 6'h26;
   localparam funct_t fn_nor  = 6'h27;
   localparam funct_t fn_slt  = 6'h2a;
   localparam funct_t fn_sltu = 6'h2b;

   // hardwired zero register
   localparam reg_idx_t reg_ra_zero = 5'd0;

endpackage

// File: hdl/pipe_pkg.sv
package pipe_pkg;

   // execute unit operations
   typedef enum logic [3:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor,
      alu_nor,
      alu_slt,
      alu_sltu,
      alu_sll,
      alu_srl,
      alu_sra,
      alu_lui
   } alu_op_e;

   // where an execute operand comes from
   typedef enum logic [1:0] {
      fwd_none = 2'd0,
      fwd_mem  = 2'd1,
      fwd_wb   = 2'd2
   } fwd_sel_e;

   // control word, follows the instruction down the pipe
   typedef struct packed {
      logic    reg_we;
      logic    mem_re;
      logic    mem_we;
      logic    use_imm;
      alu_op_e alu_op;
   } ctrl_t;

   // empty control word, used for bubbles and unknown opcodes
   localparam ctrl_t ctrl_nop = '0;

   // decode to execute register
   typedef struct packed {
      ctrl_t                 ctrl;
      mips_isa_pkg::word_t    rs_val;
      mips_isa_pkg::word_t    rt_val;
      mips_isa_pkg::word_t    imm;
      mips_isa_pkg::shamt_t   shamt;
      mips_isa_pkg::reg_idx_t rs;
      mips_isa_pkg::reg_idx_t rt;
      mips_isa_pkg::reg_idx_t dst;
   } ex_stage_t;

   // execute to memory register
   typedef struct packed {
      ctrl_t                 ctrl;
      mips_isa_pkg::word_t    alu_res;
      mips_isa_pkg::word_t    st_data;
      mips_isa_pkg::reg_idx_t dst;
   } mem_stage_t;

   // memory to writeback register
   typedef struct packed {
      logic                  reg_we;
      mips_isa_pkg::reg_idx_t dst;
      mips_isa_pkg::word_t    result;
   } wb_stage_t;

endpackage

// File: hdl/mips_alu.sv
module mips_alu (
   input  pipe_pkg::alu_op_e    op,
   input  mips_isa_pkg::word_t  a,
   input  mips_isa_pkg::word_t  b,
   input  mips_isa_pkg::shamt_t shamt,
   output mips_isa_pkg::word_t  result
);

   always_comb begin
      case (op)
         // add and sub wrap, no overflow trap
         pipe_pkg::alu_add:  result = a + b;
         pipe_pkg::alu_sub:  result = a - b;
         pipe_pkg::alu_and:  result = a & b;
         pipe_pkg::alu_or:   result = a | b;
         pipe_pkg::alu_xor:  result = a ^ b;
         pipe_pkg::alu_nor:  result = ~(a | b);
         pipe_pkg::alu_slt:  result = {31'd0, $signed(a) < $signed(b)};
         pipe_pkg::alu_sltu: result = {31'd0, a < b};
         // fixed shifts act on rt, amount from the instruction
         pipe_pkg::alu_sll:  result = b << shamt;
         pipe_pkg::alu_srl:  result = b >> shamt;
         pipe_pkg::alu_sra:  result = $signed(b) >>> shamt;
         // immediate moves to the upper half
         pipe_pkg::alu_lui:  result = {b[15:0], 16'h0000};
         default:            result = '0;
      endcase
   end

endmodule

// File: hdl/mips_decode.sv
module mips_decode (
   input  mips_isa_pkg::word_t instr,
   output pipe_pkg::ctrl_t     ctrl,
   output mips_isa_pkg::word_t imm
);

   mips_isa_pkg::instr_t f;
   mips_isa_pkg::imm16_t imm16;
   logic                 sext;

   assign f     = mips_isa_pkg::instr_t'(instr);
   // immediate sits over rd, shamt and funct
   assign imm16 = instr[15:0];
   assign imm   = sext ? {{16{imm16[15]}}, imm16} : {16'h0000, imm16};

   always_comb begin
      ctrl = pipe_pkg::ctrl_nop;
      sext = 1'b0;
      case (f.opcode)
         mips_isa_pkg::op_rtype: begin
            ctrl.reg_we = 1'b1;
            case (f.funct)
               mips_isa_pkg::fn_sll:  ctrl.alu_op = pipe_pkg::alu_sll;
               mips_isa_pkg::fn_srl:  ctrl.alu_op = pipe_pkg::alu_srl;
               mips_isa_pkg::fn_sra:  ctrl.alu_op = pipe_pkg::alu_sra;
               // overflow traps are not modelled, add behaves as addu
               mips_isa_pkg::fn_add:  ctrl.alu_op = pipe_pkg::alu_add;
               mips_isa_pkg::fn_addu: ctrl.alu_op = pipe_pkg::alu_add;
               mips_isa_pkg::fn_sub:  ctrl.alu_op = pipe_pkg::alu_sub;
               mips_isa_pkg::fn_subu: ctrl.alu_op = pipe_pkg::alu_sub;
               mips_isa_pkg::fn_and:  ctrl.alu_op = pipe_pkg::alu_and;
               mips_isa_pkg::fn_or:   ctrl.alu_op = pipe_pkg::alu_or;
               mips_isa_pkg::fn_xor:  ctrl.alu_op = pipe_pkg::alu_xor;
               mips_isa_pkg::fn_nor:  ctrl.alu_op = pipe_pkg::alu_nor;
               mips_isa_pkg::fn_slt:  ctrl.alu_op = pipe_pkg::alu_slt;
               mips_isa_pkg::fn_sltu: ctrl.alu_op = pipe_pkg::alu_sltu;
               // unknown function code becomes a no-op
               default:               ctrl = pipe_pkg::ctrl_nop;
            endcase
         end
         mips_isa_pkg::op_addi, mips_isa_pkg::op_addiu: begin
            ctrl = '{reg_we: 1'b1, mem_re: 1'b0, mem_we: 1'b0, use_imm: 1'b1,
                     alu_op: pipe_pkg::alu_add};
            sext = 1'b1;
         end
         mips_isa_pkg::op_slti: begin
            ctrl = '{reg_we: 1'b1, mem_re: 1'b0, mem_we: 1'b0, use_imm: 1'b1,
                     alu_op: pipe_pkg::alu_slt};
            sext = 1'b1;
         end
         // logical immediates are zero extended
         mips_isa_pkg::op_andi: ctrl = '{1'b1, 1'b0, 1'b0, 1'b1, pipe_pkg::alu_and};
         mips_isa_pkg::op_ori:  ctrl = '{1'b1, 1'b0, 1'b0, 1'b1, pipe_pkg::alu_or};
         mips_isa_pkg::op_xori: ctrl = '{1'b1, 1'b0, 1'b0, 1'b1, pipe_pkg::alu_xor};
         mips_isa_pkg::op_lui:  ctrl = '{1'b1, 1'b0, 1'b0, 1'b1, pipe_pkg::alu_lui};
         // address is base plus signed offset
         mips_isa_pkg::op_lw: begin
            ctrl = '{1'b1, 1'b1, 1'b0, 1'b1, pipe_pkg::alu_add};
            sext = 1'b1;
         end
         mips_isa_pkg::op_sw: begin
            ctrl = '{1'b0, 1'b0, 1'b1, 1'b1, pipe_pkg::alu_add};
            sext = 1'b1;
         end
         default: ctrl = pipe_pkg::ctrl_nop;
      endcase
   end

endmodule

// File: hdl/reg_file.sv
module reg_file (
   input  logic                   clk,
   input  logic                   rst_b,
   input  mips_isa_pkg::reg_idx_t rs_num,
   input  mips_isa_pkg::reg_idx_t rt_num,
   output mips_isa_pkg::word_t    rs_data,
   output mips_isa_pkg::word_t    rt_data,
   input  logic                   wr_en,
   input  mips_isa_pkg::reg_idx_t wr_num,
   input  mips_isa_pkg::word_t    wr_data
);

   // entry 0 is never written, so it always reads zero
   mips_isa_pkg::word_t regs [32];
   logic                wr_live;

   assign wr_live = wr_en && (wr_num != mips_isa_pkg::reg_ra_zero);

   // same-cycle write is seen by the decode-stage read
   assign rs_data = (wr_live && wr_num == rs_num) ? wr_data : regs[rs_num];
   assign rt_data = (wr_live && wr_num == rt_num) ? wr_data : regs[rt_num];

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_live) begin
         regs[wr_num] <= wr_data;
      end
   end

endmodule

// File: hdl/hazard_unit.sv
module hazard_unit (
   input  mips_isa_pkg::reg_idx_t id_rs,
   input  mips_isa_pkg::reg_idx_t id_rt,
   input  logic                   id_reads_rt,
   input  pipe_pkg::ex_stage_t    ex,
   input  mips_isa_pkg::reg_idx_t mem_dst,
   input  logic                   mem_reg_we,
   input  pipe_pkg::wb_stage_t    wb,
   output pipe_pkg::fwd_sel_e     fwd_rs,
   output pipe_pkg::fwd_sel_e     fwd_rt,
   output logic                   stall
);

   logic load_in_ex;

   // memory stage is younger than writeback, so it wins
   // register 0 never forwards
   function automatic pipe_pkg::fwd_sel_e pick(mips_isa_pkg::reg_idx_t src,
         mips_isa_pkg::reg_idx_t m_dst, logic m_we, pipe_pkg::wb_stage_t w);
      if (src == mips_isa_pkg::reg_ra_zero) begin
         pick = pipe_pkg::fwd_none;
      end else if (m_we && m_dst == src) begin
         pick = pipe_pkg::fwd_mem;
      end else if (w.reg_we && w.dst == src) begin
         pick = pipe_pkg::fwd_wb;
      end else begin
         pick = pipe_pkg::fwd_none;
      end
   endfunction

   assign fwd_rs = pick(ex.rs, mem_dst, mem_reg_we, wb);
   assign fwd_rt = pick(ex.rt, mem_dst, mem_reg_we, wb);

   // load result is only ready at the end of the memory stage
   assign load_in_ex = ex.ctrl.mem_re && (ex.dst != mips_isa_pkg::reg_ra_zero);
   // one bubble lets memory forwarding pick up the load data
   assign stall = load_in_ex &&
                  ((ex.dst == id_rs) || (id_reads_rt && ex.dst == id_rt));

endmodule

// File: hdl/mips_pipe_core.sv
module mips_pipe_core #(
   parameter mips_isa_pkg::word_t text_start = 32'h0040_0000
) (
   input  logic                 clk,
   input  logic                 rst_b,
   output mips_isa_pkg::waddr_t inst_addr,
   input  mips_isa_pkg::word_t  inst,
   output mips_isa_pkg::waddr_t mem_addr,
   output mips_isa_pkg::word_t  mem_wdata,
   output logic                 mem_we,
   input  mips_isa_pkg::word_t  mem_rdata
);

   // fetch and decode
   mips_isa_pkg::waddr_t   pc;
   mips_isa_pkg::word_t    id_instr;
   mips_isa_pkg::instr_t   id_f;
   pipe_pkg::ctrl_t        id_ctrl;
   mips_isa_pkg::word_t    id_imm;
   mips_isa_pkg::word_t    rs_data;
   mips_isa_pkg::word_t    rt_data;
   mips_isa_pkg::reg_idx_t id_dst;
   logic                   id_reads_rt;
   logic                   stall;
   // execute
   pipe_pkg::ex_stage_t    ex_d;
   pipe_pkg::ex_stage_t    ex_q;
   pipe_pkg::fwd_sel_e     fwd_rs;
   pipe_pkg::fwd_sel_e     fwd_rt;
   mips_isa_pkg::word_t    rs_fwd;
   mips_isa_pkg::word_t    rt_fwd;
   mips_isa_pkg::word_t    alu_b;
   mips_isa_pkg::word_t    alu_res;
   // memory and writeback
   pipe_pkg::mem_stage_t   mem_q;
   mips_isa_pkg::word_t    mem_result;
   pipe_pkg::wb_stage_t    wb_q;

   // operand source, nearest stage already resolved by the hazard unit
   function automatic mips_isa_pkg::word_t fwd_pick(pipe_pkg::fwd_sel_e sel,
         mips_isa_pkg::word_t reg_val, mips_isa_pkg::word_t mem_val,
         mips_isa_pkg::word_t wb_val);
      case (sel)
         pipe_pkg::fwd_mem: fwd_pick = mem_val;
         pipe_pkg::fwd_wb:  fwd_pick = wb_val;
         default:           fwd_pick = reg_val;
      endcase
   endfunction

   assign inst_addr = pc;
   assign id_f = mips_isa_pkg::instr_t'(id_instr);
   // rt is a source for r-type and for the store data
   assign id_reads_rt = (id_f.opcode == mips_isa_pkg::op_rtype) ||
                        (id_f.opcode == mips_isa_pkg::op_sw);
   // r-type writes rd, immediate forms write rt
   assign id_dst = (id_f.opcode == mips_isa_pkg::op_rtype) ? id_f.rd : id_f.rt;

   mips_decode u_decode (.instr(id_instr), .ctrl(id_ctrl), .imm(id_imm));

   reg_file u_regs (
      .clk(clk), .rst_b(rst_b),
      .rs_num(id_f.rs), .rt_num(id_f.rt), .rs_data(rs_data), .rt_data(rt_data),
      .wr_en(wb_q.reg_we), .wr_num(wb_q.dst), .wr_data(wb_q.result)
   );

   hazard_unit u_hazard (
      .id_rs(id_f.rs), .id_rt(id_f.rt), .id_reads_rt(id_reads_rt), .ex(ex_q),
      .mem_dst(mem_q.dst), .mem_reg_we(mem_q.ctrl.reg_we), .wb(wb_q),
      .fwd_rs(fwd_rs), .fwd_rt(fwd_rt), .stall(stall)
   );

   // next execute entry, bubble while stalled
   always_comb begin
      ex_d.ctrl   = stall ? pipe_pkg::ctrl_nop : id_ctrl;
      ex_d.rs_val = rs_data;
      ex_d.rt_val = rt_data;
      ex_d.imm    = id_imm;
      ex_d.shamt  = id_f.shamt;
      ex_d.rs     = id_f.rs;
      ex_d.rt     = id_f.rt;
      ex_d.dst    = id_dst;
   end

   assign rs_fwd = fwd_pick(fwd_rs, ex_q.rs_val, mem_result, wb_q.result);
   assign rt_fwd = fwd_pick(fwd_rt, ex_q.rt_val, mem_result, wb_q.result);
   assign alu_b  = ex_q.ctrl.use_imm ? ex_q.imm : rt_fwd;

   mips_alu u_alu (.op(ex_q.ctrl.alu_op), .a(rs_fwd), .b(alu_b), .shamt(ex_q.shamt),
                   .result(alu_res));

   // data port, word access only
   assign mem_addr   = mem_q.alu_res[31:2];
   assign mem_wdata  = mem_q.st_data;
   assign mem_we     = mem_q.ctrl.mem_we;
   // load data arrives in the same cycle
   assign mem_result = mem_q.ctrl.mem_re ? mem_rdata : mem_q.alu_res;

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc       <= text_start[31:2];
         id_instr <= '0;
         ex_q     <= '0;
         mem_q    <= '0;
         wb_q     <= '0;
      end else begin
         // fetch and decode hold on a load-use interlock
         if (!stall) begin
            pc       <= pc + 30'd1;
            id_instr <= inst;
         end
         ex_q  <= ex_d;
         mem_q <= '{ctrl: ex_q.ctrl, alu_res: alu_res, st_data: rt_fwd, dst: ex_q.dst};
         wb_q  <= '{reg_we: mem_q.ctrl.reg_we, dst: mem_q.dst, result: mem_result};
      end
   end

endmodule

// File: tb/tb_clk_gen.sv
module tb_clk_gen #(
   parameter int period = 100
) (
   output logic clk
);

   // free running clock, low for the first half period
   initial begin
      clk = 1'b0;
      forever begin
         #(period / 2) clk = ~clk;
      end
   end

endmodule

// File: tb/mips_pipe_sva.sv
module mips_pipe_sva (
   input logic                 clk,
   input logic                 rst_b,
   input mips_isa_pkg::waddr_t inst_addr,
   input mips_isa_pkg::waddr_t mem_addr,
   input logic                 mem_we
);

   // write strobe is always driven once out of reset
   mem_we_known: assert property (@(posedge clk) disable iff (!rst_b)
      !$isunknown(mem_we))
      else $error("mem_we is unknown");

   // no branches, so fetch only increments or holds on a stall
   pc_step: assert property (@(posedge clk) disable iff (!rst_b)
      (inst_addr == $past(inst_addr)) || (inst_addr == $past(inst_addr) + 30'd1))
      else $error("inst_addr moved by more than one word");

   // a store must present a real address
   store_addr_known: assert property (@(posedge clk) disable iff (!rst_b)
      mem_we |-> !$isunknown(mem_addr))
      else $error("mem_addr is unknown during a store");

endmodule

bind mips_pipe_core mips_pipe_sva u_sva (
   .clk(clk),
   .rst_b(rst_b),
   .inst_addr(inst_addr),
   .mem_addr(mem_addr),
   .mem_we(mem_we)
);

// File: tb/tb_mips_pipe.sv
module tb_mips_pipe;

   localparam mips_isa_pkg::word_t  text_start = 32'h0040_0000;
   localparam mips_isa_pkg::waddr_t text_base  = text_start[31:2];
   // cycle budget per program well above fetch time plus stalls
   localparam int run_limit = 2000;

   logic                 clk;
   logic                 rst_b = 1'b0;
   mips_isa_pkg::waddr_t inst_addr;
   mips_isa_pkg::word_t  inst = '0;
   mips_isa_pkg::waddr_t mem_addr;
   mips_isa_pkg::word_t  mem_wdata;
   logic                 mem_we;
   mips_isa_pkg::word_t  mem_rdata = '0;

   // program image, data memory and the expected store list
   mips_isa_pkg::word_t  prog [$];
   mips_isa_pkg::word_t  dmem [64];
   mips_isa_pkg::waddr_t exp_addr [$];
   mips_isa_pkg::word_t  exp_data [$];
   int                   exp_idx;
   int                   fetch_idx;
   string                test_name;

   tb_clk_gen #(.period(100)) u_clk (.clk(clk));

   mips_pipe_core #(.text_start(text_start)) uut (
      .clk(clk), .rst_b(rst_b), .inst_addr(inst_addr), .inst(inst),
      .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_we(mem_we), .mem_rdata(mem_rdata)
   );

   task automatic abort(input string why);
      $display("%s", why);
      $display("SIMULATION FAILED");
      $fatal(1, "stopped on first error");
   endtask

   task automatic check(input string what, input mips_isa_pkg::word_t expected,
         input mips_isa_pkg::word_t actual);
      if (expected !== actual) begin
         abort($sformatf("ERR %s %s: expected %h, actual %h", test_name, what,
                         expected, actual));
      end
   endtask

   function automatic mips_isa_pkg::word_t enc_r(mips_isa_pkg::funct_t fn,
         mips_isa_pkg::reg_idx_t rd, mips_isa_pkg::reg_idx_t rs,
         mips_isa_pkg::reg_idx_t rt, mips_isa_pkg::shamt_t sh);
      return {mips_isa_pkg::op_rtype, rs, rt, rd, sh, fn};
   endfunction

   function automatic mips_isa_pkg::word_t enc_i(mips_isa_pkg::opcode_t op,
         mips_isa_pkg::reg_idx_t rt, mips_isa_pkg::reg_idx_t rs, mips_isa_pkg::imm16_t imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic mips_isa_pkg::reg_idx_t rand_reg();
      return mips_isa_pkg::reg_idx_t'($urandom_range(31, 0));
   endfunction

   // sw of registers first..last to word base+i with base register 0
   task automatic emit_stores(input int first, input int last, input int base);
      for (int i = first; i <= last; i++) begin
         prog.push_back(enc_i(mips_isa_pkg::op_sw, mips_isa_pkg::reg_idx_t'(i), 5'd0,
                              mips_isa_pkg::imm16_t'((base + i) * 4)));
      end
   endtask

   // in-order ISA model that fills the expected store list
   function automatic void run_model();
      mips_isa_pkg::word_t    r [32];
      mips_isa_pkg::word_t    m [64];
      mips_isa_pkg::instr_t   f;
      mips_isa_pkg::word_t    a;
      mips_isa_pkg::word_t    b;
      mips_isa_pkg::word_t    simm;
      mips_isa_pkg::word_t    zimm;
      mips_isa_pkg::word_t    ea;
      mips_isa_pkg::word_t    res;
      mips_isa_pkg::reg_idx_t dst;
      logic                   wr;
      foreach (r[i]) r[i] = '0;
      foreach (m[i]) m[i] = '0;
      exp_addr.delete();
      exp_data.delete();
      foreach (prog[k]) begin
         f    = mips_isa_pkg::instr_t'(prog[k]);
         a    = r[f.rs];
         b    = r[f.rt];
         simm = {{16{prog[k][15]}}, prog[k][15:0]};
         zimm = {16'h0000, prog[k][15:0]};
         ea   = a + simm;
         res  = '0;
         dst  = f.rt;
         wr   = 1'b1;
         case (f.opcode)
            mips_isa_pkg::op_rtype: begin
               dst = f.rd;
               case (f.funct)
                  mips_isa_pkg::fn_sll:  res = b << f.shamt;
                  mips_isa_pkg::fn_srl:  res = b >> f.shamt;
                  mips_isa_pkg::fn_sra:  res = $signed(b) >>> f.shamt;
                  mips_isa_pkg::fn_add:  res = a + b;
                  mips_isa_pkg::fn_addu: res = a + b;
                  mips_isa_pkg::fn_sub:  res = a - b;
                  mips_isa_pkg::fn_subu: res = a - b;
                  mips_isa_pkg::fn_and:  res = a & b;
                  mips_isa_pkg::fn_or:   res = a | b;
                  mips_isa_pkg::fn_xor:  res = a ^ b;
                  mips_isa_pkg::fn_nor:  res = ~(a | b);
                  mips_isa_pkg::fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  mips_isa_pkg::fn_sltu: res = (a < b) ? 32'd1 : 32'd0;
                  default:               wr = 1'b0;
               endcase
            end
            mips_isa_pkg::op_addi:  res = a + simm;
            mips_isa_pkg::op_addiu: res = a + simm;
            mips_isa_pkg::op_slti:  res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
            mips_isa_pkg::op_andi:  res = a & zimm;
            mips_isa_pkg::op_ori:   res = a | zimm;
            mips_isa_pkg::op_xori:  res = a ^ zimm;
            mips_isa_pkg::op_lui:   res = {prog[k][15:0], 16'h0000};
            mips_isa_pkg::op_lw:    res = m[ea[7:2]];
            mips_isa_pkg::op_sw: begin
               wr = 1'b0;
               m[ea[7:2]] = b;
               exp_addr.push_back(ea[31:2]);
               exp_data.push_back(b);
            end
            default: wr = 1'b0;
         endcase
         // register 0 ignores every write
         if (wr && dst != 5'd0) begin
            r[dst] = res;
         end
      end
   endfunction

   // every alu and immediate form with results stored to words 1..19
   task automatic build_alu_prog();
      mips_isa_pkg::funct_t fns [13] = '{mips_isa_pkg::fn_add, mips_isa_pkg::fn_addu,
         mips_isa_pkg::fn_sub, mips_isa_pkg::fn_subu, mips_isa_pkg::fn_and,
         mips_isa_pkg::fn_or, mips_isa_pkg::fn_xor, mips_isa_pkg::fn_nor,
         mips_isa_pkg::fn_slt, mips_isa_pkg::fn_sltu, mips_isa_pkg::fn_sll,
         mips_isa_pkg::fn_srl, mips_isa_pkg::fn_sra};
      prog.delete();
      prog.push_back(enc_i(mips_isa_pkg::op_lui, 5'd1, 5'd0, 16'h8123));
      prog.push_back(enc_i(mips_isa_pkg::op_ori, 5'd1, 5'd1, 16'h4567));
      prog.push_back(enc_i(mips_isa_pkg::op_addiu, 5'd2, 5'd0, 16'hfff3));
      prog.push_back(enc_i(mips_isa_pkg::op_addi, 5'd3, 5'd2, 16'h7ff0));
      prog.push_back(enc_i(mips_isa_pkg::op_andi, 5'd4, 5'd1, 16'hf0f0));
      prog.push_back(enc_i(mips_isa_pkg::op_xori, 5'd5, 5'd1, 16'hffff));
      // signed compare of -13 against -8
      prog.push_back(enc_i(mips_isa_pkg::op_slti, 5'd6, 5'd2, 16'hfff8));
      for (int i = 0; i < 13; i++) begin
         // shifts take rt and shamt and leave rs at zero
         prog.push_back(enc_r(fns[i], mips_isa_pkg::reg_idx_t'(7 + i),
                              (i >= 10) ? 5'd0 : 5'd2, 5'd1, (i >= 10) ? 5'd5 : 5'd0));
      end
      emit_stores(1, 19, 0);
   endtask

   // readers at distance 1, 2 and 3 from their producers
   task automatic build_fwd_prog();
      prog.delete();
      prog.push_back(enc_i(mips_isa_pkg::op_addiu, 5'd1, 5'd0, 16'h0011));
      prog.push_back(enc_r(mips_isa_pkg::fn_addu, 5'd2, 5'd1, 5'd1, 5'd0));
      prog.push_back(enc_r(mips_isa_pkg::fn_xor, 5'd3, 5'd1, 5'd2, 5'd0));
      prog.push_back(enc_r(mips_isa_pkg::fn_or, 5'd4, 5'd1, 5'd3, 5'd0));
      prog.push_back(enc_r(mips_isa_pkg::fn_subu, 5'd5, 5'd2, 5'd4, 5'd0));
      prog.push_back(enc_r(mips_isa_pkg::fn_sll, 5'd6, 5'd0, 5'd5, 5'd3));
      // store data forwarded from the instruction just ahead
      prog.push_back(enc_i(mips_isa_pkg::op_sw, 5'd6, 5'd0, 16'd24));
      emit_stores(1, 6, 8);
   endtask

   // loads used at once as rs, as rt and as store data
   task automatic build_load_use_prog();
      prog.delete();
      prog.push_back(enc_i(mips_isa_pkg::op_addiu, 5'd1, 5'd0, 16'h1234));
      prog.push_back(enc_i(mips_isa_pkg::op_sw, 5'd1, 5'd0, 16'd8));
      prog.push_back(enc_i(mips_isa_pkg::op_addiu, 5'd2, 5'd0, 16'd4));
      prog.push_back(enc_i(mips_isa_pkg::op_lw, 5'd3, 5'd2, 16'd4));
      prog.push_back(enc_i(mips_isa_pkg::op_addiu, 5'd4, 5'd3, 16'd1));
      prog.push_back(enc_i(mips_isa_pkg::op_lw, 5'd5, 5'd0, 16'd8));
      prog.push_back(enc_r(mips_isa_pkg::fn_subu, 5'd6, 5'd1, 5'd5, 5'd0));
      prog.push_back(enc_i(mips_isa_pkg::op_lw, 5'd7, 5'd0, 16'd8));
      prog.push_back(enc_i(mips_isa_pkg::op_sw, 5'd7, 5'd0, 16'd12));
      prog.push_back(enc_i(mips_isa_pkg::op_lw, 5'd8, 5'd0, 16'd12));
      prog.push_back(enc_r(mips_isa_pkg::fn_addu, 5'd9, 5'd8, 5'd8, 5'd0));
      emit_stores(1, 9, 16);
   endtask

   // writes to register 0 from alu, immediate and load forms
   task automatic build_zero_prog();
      prog.delete();
      prog.push_back(enc_i(mips_isa_pkg::op_addiu, 5'd1, 5'd0, 16'h5a5a));
      prog.push_back(enc_i(mips_isa_pkg::op_sw, 5'd1, 5'd0, 16'd4));
      prog.push_back(enc_i(mips_isa_pkg::op_addiu, 5'd0, 5'd0, 16'h0037));
      prog.push_back(enc_i(mips_isa_pkg::op_lui, 5'd0, 5'd0, 16'hffff));
      prog.push_back(enc_r(mips_isa_pkg::fn_addu, 5'd0, 5'd1, 5'd1, 5'd0));
      prog.push_back(enc_i(mips_isa_pkg::op_lw, 5'd0, 5'd0, 16'd4));
      prog.push_back(enc_r(mips_isa_pkg::fn_addu, 5'd2, 5'd0, 5'd0, 5'd0));
      prog.push_back(enc_r(mips_isa_pkg::fn_or, 5'd3, 5'd0, 5'd1, 5'd0));
      prog.push_back(enc_i(mips_isa_pkg::op_sw, 5'd0, 5'd0, 16'd8));
      emit_stores(2, 3, 4);
   endtask

   // random mix with memory offsets kept inside the 64 words
   task automatic build_random_prog(input int count);
      int                     kind;
      int                     pick;
      mips_isa_pkg::funct_t   fn;
      mips_isa_pkg::imm16_t   imm;
      mips_isa_pkg::imm16_t   offs;
      mips_isa_pkg::funct_t   fns [13] = '{mips_isa_pkg::fn_add, mips_isa_pkg::fn_addu,
         mips_isa_pkg::fn_sub, mips_isa_pkg::fn_subu, mips_isa_pkg::fn_and,
         mips_isa_pkg::fn_or, mips_isa_pkg::fn_xor, mips_isa_pkg::fn_nor,
         mips_isa_pkg::fn_slt, mips_isa_pkg::fn_sltu, mips_isa_pkg::fn_sll,
         mips_isa_pkg::fn_srl, mips_isa_pkg::fn_sra};
      mips_isa_pkg::opcode_t  ops [7] = '{mips_isa_pkg::op_addi, mips_isa_pkg::op_addiu,
         mips_isa_pkg::op_slti, mips_isa_pkg::op_andi, mips_isa_pkg::op_ori,
         mips_isa_pkg::op_xori, mips_isa_pkg::op_lui};
      prog.delete();
      for (int i = 0; i < count; i++) begin
         kind = $urandom_range(9, 0);
         imm  = mips_isa_pkg::imm16_t'($urandom());
         offs = mips_isa_pkg::imm16_t'($urandom_range(63, 0) * 4);
         if (kind < 4) begin
            pick = $urandom_range(12, 0);
            fn   = fns[pick];
            if (pick >= 10) begin
               prog.push_back(enc_r(fn, rand_reg(), 5'd0, rand_reg(),
                                    mips_isa_pkg::shamt_t'($urandom_range(31, 0))));
            end else begin
               prog.push_back(enc_r(fn, rand_reg(), rand_reg(), rand_reg(), 5'd0));
            end
         end else if (kind < 7) begin
            pick = $urandom_range(6, 0);
            prog.push_back(enc_i(ops[pick], rand_reg(), rand_reg(), imm));
         end else if (kind < 9) begin
            prog.push_back(enc_i(mips_isa_pkg::op_lw, rand_reg(), 5'd0, offs));
         end else begin
            prog.push_back(enc_i(mips_isa_pkg::op_sw, rand_reg(), 5'd0, offs));
         end
      end
      // final dump of every register to words 33..63
      emit_stores(1, 31, 32);
   endtask

   // program and data memory answer on the falling edge
   always @(negedge clk) begin
      fetch_idx = int'(inst_addr - text_base);
      // past the end of the program the core sees no-ops
      inst      = (fetch_idx >= 0 && fetch_idx < prog.size()) ? prog[fetch_idx] : '0;
      mem_rdata = dmem[mem_addr[5:0]];
   end

   // store compare and data memory write
   always @(posedge clk) begin
      if (!rst_b) begin
         exp_idx <= 0;
         foreach (dmem[i]) dmem[i] <= '0;
      end else if (mem_we) begin
         if (exp_idx >= exp_addr.size()) begin
            abort($sformatf("%s: store to word %h that the program does not make",
                            test_name, mem_addr));
         end else begin
            check("store addr", {2'b00, exp_addr[exp_idx]}, {2'b00, mem_addr});
            check("store data", exp_data[exp_idx], mem_wdata);
         end
         dmem[mem_addr[5:0]] <= mem_wdata;
         exp_idx <= exp_idx + 1;
      end
   end

   task automatic run_program(input string name);
      int cycles;
      test_name = name;
      run_model();
      rst_b = 1'b0;
      // reset state holds for the whole reset window
      repeat (16) begin
         @(negedge clk);
         check("reset mem_we", 32'd0, {31'd0, mem_we});
         check("reset inst_addr", {2'b00, text_base}, {2'b00, inst_addr});
      end
      rst_b = 1'b1;
      // first edge out of reset fetches one word and stores nothing yet
      @(negedge clk);
      check("release mem_we", 32'd0, {31'd0, mem_we});
      check("release inst_addr", {2'b00, text_base + 30'd1}, {2'b00, inst_addr});
      cycles = 0;
      while (exp_idx < exp_addr.size()) begin
         @(negedge clk);
         cycles++;
         if (cycles > run_limit) begin
            abort($sformatf("timeout in %s: only %0d of %0d stores seen", name, exp_idx,
                            exp_addr.size()));
         end
      end
      // let the pipe drain while no further store may appear
      repeat (8) @(negedge clk);
   endtask

   initial begin
      void'($urandom(77));
      build_alu_prog();
      run_program("alu_ops");
      build_fwd_prog();
      run_program("forwarding");
      build_load_use_prog();
      run_program("load_use");
      build_zero_prog();
      run_program("reg_zero");
      build_random_prog(200);
      run_program("random");
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

// File: project.f
hdl/mips_isa_pkg.sv
hdl/pipe_pkg.sv
hdl/mips_alu.sv
hdl/mips_decode.sv
hdl/reg_file.sv
hdl/hazard_unit.sv
hdl/mips_pipe_core.sv
tb/tb_clk_gen.sv
tb/mips_pipe_sva.sv
tb/tb_mips_pipe.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
verilator --binary --timing --assert -f project.f --top-module tb_mips_pipe \
   -Mdir obj_dir -o tb_mips_pipe > build.log 2>&1 \
   && ./obj_dir/tb_mips_pipe > sim.log 2>&1 \
   && grep -q "SIMULATION PASSED" sim.log \
   && echo "run passed" \
   || { echo "run failed, see build.log and sim.log"; exit 1; }
